// ==== design/fe_defines.svh ====
// ----------------------------------------
// fetch frontend constants
// widths, queue depth, pc step, opcodes
// ----------------------------------------
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// address and instruction width
`define FE_XLEN 32

// entries in the fetch queue, power of two
`define FE_QUEUE_DEPTH 4

// sequential pc step, only 32-bit instructions
`define FE_INSTR_BYTES 4

// pc value while in reset, boot address is loaded afterwards
`define FE_PC_RST {`FE_XLEN{1'b0}}

// major opcodes seen by the scanner
`define FE_OPC_BRANCH 7'b1100011
`define FE_OPC_JAL    7'b1101111

`endif

// ==== design/fe_isa_pkg.sv ====
// ----------------------------------------
// instruction formats for the scanner
// b-type and j-type views, union, cf kind
// ----------------------------------------
`include "fe_defines.svh"

package fe_isa_pkg;

    // raw instruction word
    typedef logic [`FE_XLEN-1:0] instr_t;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } btype_t;

    // jal layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jtype_t;

    // one fetched word, decoded both ways
    typedef union packed {
        instr_t raw;
        btype_t btype;
        jtype_t jtype;
    } instr_u;

    // control-flow kind of a fetched word
    typedef enum logic [1:0] {
        NONE   = 2'd0,
        BRANCH = 2'd1,
        JUMP   = 2'd2
    } cf_e;

endpackage

// ==== design/fe_pipe_pkg.sv ====
// ----------------------------------------
// pipeline types of the fetch frontend
// byte address and queue occupancy
// ----------------------------------------
`include "fe_defines.svh"

package fe_pipe_pkg;

    // byte address of an instruction
    typedef logic [`FE_XLEN-1:0] addr_t;

    // occupancy counter, has to hold 0 up to the full depth
    typedef logic [$clog2(`FE_QUEUE_DEPTH+1)-1:0] qcount_t;

endpackage

// ==== design/fe_pc_gen.sv ====
// ----------------------------------------
// pc generation and memory request side
// outstanding request and kill tracking
// ----------------------------------------
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_pc_gen (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  fe_pipe_pkg::addr_t boot_addr_i,
    input  logic               redirect_i,
    input  fe_pipe_pkg::addr_t redirect_pc_i,
    input  logic               pred_taken_i,
    input  fe_pipe_pkg::addr_t pred_target_i,
    input  logic               has_room_i,
    output logic               mem_req_o,
    output fe_pipe_pkg::addr_t mem_addr_o,
    input  logic               mem_gnt_i,
    input  logic               mem_rvalid_i,
    input  fe_isa_pkg::instr_t mem_rdata_i,
    output logic               rsp_valid_o,
    output fe_pipe_pkg::addr_t rsp_pc_o,
    output fe_isa_pkg::instr_t rsp_instr_o
);
    import fe_pipe_pkg::*;

    // set while in reset and for one cycle after it
    logic  rst_load_q;
    addr_t pc_d, pc_q;
    // a stalled request stays up with the same address
    logic  hold_q;
    // target that arrived while the request was stalled
    addr_t tgt_q;
    logic  tgt_vld_d, tgt_vld_q;
    // request in flight, answered in the next cycle
    addr_t out_addr_q;
    logic  out_kill_q;
    logic  stall, accept, new_tgt;
    addr_t new_addr;

    assign mem_req_o  = ~rst_load_q & (has_room_i | hold_q);
    assign mem_addr_o = pc_q;
    assign stall      = mem_req_o & ~mem_gnt_i;
    assign accept     = mem_req_o & mem_gnt_i;

    // back-end redirect wins over the static prediction
    assign new_tgt  = redirect_i | pred_taken_i;
    assign new_addr = redirect_i ? redirect_pc_i : pred_target_i;

    // ----------------------------------------
    // next pc
    // ----------------------------------------
    always_comb begin
        pc_d      = pc_q;
        tgt_vld_d = 1'b0;
        if (rst_load_q) begin
            pc_d = boot_addr_i;
        end else if (stall) begin
            // address must not move, park the new target
            tgt_vld_d = tgt_vld_q | new_tgt;
        end else if (new_tgt) begin
            pc_d = new_addr;
        end else if (tgt_vld_q) begin
            // stale request just went out, continue at parked target
            pc_d = tgt_q;
        end else if (accept) begin
            pc_d = pc_q + `FE_INSTR_BYTES;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rst_load_q <= 1'b1;
            pc_q       <= `FE_PC_RST;
            hold_q     <= 1'b0;
            tgt_vld_q  <= 1'b0;
            out_kill_q <= 1'b0;
        end else begin
            rst_load_q <= 1'b0;
            pc_q       <= pc_d;
            hold_q     <= stall;
            tgt_vld_q  <= tgt_vld_d;
            // request accepted now is dead if the flow changes now
            if (accept) begin
                out_kill_q <= new_tgt | tgt_vld_q;
            end
        end
    end

    // payload of the in-flight request and the parked target
    always_ff @(posedge clk_i) begin
        if (accept) begin
            out_addr_q <= pc_q;
        end
        if (stall && new_tgt) begin
            tgt_q <= new_addr;
        end
    end

    // ----------------------------------------
    // response
    // ----------------------------------------
    // a redirect also drops the word returning in its own cycle
    assign rsp_valid_o = mem_rvalid_i & ~out_kill_q & ~redirect_i;
    assign rsp_pc_o    = out_addr_q;
    assign rsp_instr_o = mem_rdata_i;

endmodule

// ==== design/fe_branch_predict.sv ====
// ----------------------------------------
// scan of the returned word
// static prediction and target adder
// ----------------------------------------
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_branch_predict (
    input  logic               rsp_valid_i,
    input  fe_pipe_pkg::addr_t rsp_pc_i,
    input  fe_isa_pkg::instr_t rsp_instr_i,
    output logic               pred_taken_o,
    output fe_pipe_pkg::addr_t pred_target_o,
    output logic               push_o,
    output fe_pipe_pkg::addr_t push_pc_o,
    output fe_isa_pkg::instr_t push_instr_o,
    output logic               push_taken_o,
    output fe_pipe_pkg::addr_t push_npc_o
);
    import fe_isa_pkg::*;
    import fe_pipe_pkg::*;

    instr_u word;
    cf_e    cf_kind;
    addr_t  imm_b, imm_j, imm;
    addr_t  target, seq_pc;
    logic   taken;

    assign word.raw = rsp_instr_i;

    // ----------------------------------------
    // decode
    // ----------------------------------------
    // opcode sits in the same bits for both views
    always_comb begin
        unique case (word.btype.opcode)
            `FE_OPC_BRANCH: cf_kind = BRANCH;
            `FE_OPC_JAL:    cf_kind = JUMP;
            default:        cf_kind = NONE;
        endcase
    end

    // b-type immediate, 13 bits signed
    assign imm_b = {{(`FE_XLEN-12){word.btype.imm12}},
                    word.btype.imm11,
                    word.btype.imm10_5,
                    word.btype.imm4_1,
                    1'b0};

    // j-type immediate, 21 bits signed
    assign imm_j = {{(`FE_XLEN-20){word.jtype.imm20}},
                    word.jtype.imm19_12,
                    word.jtype.imm11,
                    word.jtype.imm10_1,
                    1'b0};

    assign imm = (cf_kind == JUMP) ? imm_j : imm_b;

    // ----------------------------------------
    // static rule
    // ----------------------------------------
    // jal always taken, backward branch taken
    always_comb begin
        unique case (cf_kind)
            JUMP:    taken = 1'b1;
            BRANCH:  taken = imm_b[`FE_XLEN-1];
            default: taken = 1'b0;
        endcase
    end

    assign target = rsp_pc_i + imm;
    assign seq_pc = rsp_pc_i + `FE_INSTR_BYTES;

    // redirect pc_gen only for a live word
    assign pred_taken_o  = rsp_valid_i & taken;
    assign pred_target_o = target;

    // entry for the queue carries its own prediction
    assign push_o       = rsp_valid_i;
    assign push_pc_o    = rsp_pc_i;
    assign push_instr_o = rsp_instr_i;
    assign push_taken_o = taken;
    assign push_npc_o   = taken ? target : seq_pc;

endmodule

// ==== design/fe_fetch_queue.sv ====
// ----------------------------------------
// fetch queue toward the back-end
// circular buffer with flush
// ----------------------------------------
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_fetch_queue (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  logic               push_i,
    input  fe_pipe_pkg::addr_t pc_i,
    input  fe_isa_pkg::instr_t instr_i,
    input  logic               taken_i,
    input  fe_pipe_pkg::addr_t npc_i,
    output logic               has_room_o,
    output logic               valid_o,
    output fe_pipe_pkg::addr_t pc_o,
    output fe_isa_pkg::instr_t instr_o,
    output logic               taken_o,
    output fe_pipe_pkg::addr_t npc_o,
    input  logic               ready_i
);
    import fe_isa_pkg::*;
    import fe_pipe_pkg::*;

    localparam int unsigned DEPTH = `FE_QUEUE_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);

    // entry storage
    addr_t  pc_mem    [DEPTH];
    instr_t instr_mem [DEPTH];
    logic   taken_mem [DEPTH];
    addr_t  npc_mem   [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    qcount_t          count_q;
    logic             pop;

    assign valid_o = (count_q != '0);
    assign pop     = valid_o & ready_i;

    // room for the word returning now plus one more request
    assign has_room_o = (count_q <= qcount_t'(DEPTH - 2));

    // head entry, stable until popped
    assign pc_o    = pc_mem[rd_ptr_q];
    assign instr_o = instr_mem[rd_ptr_q];
    assign taken_o = taken_mem[rd_ptr_q];
    assign npc_o   = npc_mem[rd_ptr_q];

    // ----------------------------------------
    // pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // push and pop together keep the count
            if (push_i && !pop) begin
                count_q <= count_q + qcount_t'(1);
            end else if (!push_i && pop) begin
                count_q <= count_q - qcount_t'(1);
            end
        end
    end

    // storage write
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            pc_mem[wr_ptr_q]    <= pc_i;
            instr_mem[wr_ptr_q] <= instr_i;
            taken_mem[wr_ptr_q] <= taken_i;
            npc_mem[wr_ptr_q]   <= npc_i;
        end
    end

endmodule

// ==== design/fetch_frontend.sv ====
// ----------------------------------------
// fetch frontend top level
// pc generation, predictor, fetch queue
// ----------------------------------------
`timescale 1ns/1ps

module fetch_frontend (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  fe_pipe_pkg::addr_t boot_addr_i,
    // back-end control flow change
    input  logic               redirect_i,
    input  fe_pipe_pkg::addr_t redirect_pc_i,
    // instruction memory
    output logic               mem_req_o,
    output fe_pipe_pkg::addr_t mem_addr_o,
    input  logic               mem_gnt_i,
    input  logic               mem_rvalid_i,
    input  fe_isa_pkg::instr_t mem_rdata_i,
    // fetch entries to the back-end
    output logic               fetch_valid_o,
    output fe_pipe_pkg::addr_t fetch_pc_o,
    output fe_isa_pkg::instr_t fetch_instr_o,
    output logic               fetch_taken_o,
    output fe_pipe_pkg::addr_t fetch_npc_o,
    input  logic               fetch_ready_i
);
    // response into the scanner
    logic               rsp_valid;
    fe_pipe_pkg::addr_t rsp_pc;
    fe_isa_pkg::instr_t rsp_instr;
    // prediction back to pc generation
    logic               pred_taken;
    fe_pipe_pkg::addr_t pred_target;
    // entry into the queue
    logic               push;
    fe_pipe_pkg::addr_t push_pc;
    fe_isa_pkg::instr_t push_instr;
    logic               push_taken;
    fe_pipe_pkg::addr_t push_npc;
    logic               has_room;

    fe_pc_gen i_pc_gen (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .boot_addr_i   ( boot_addr_i   ),
        .redirect_i    ( redirect_i    ),
        .redirect_pc_i ( redirect_pc_i ),
        .pred_taken_i  ( pred_taken    ),
        .pred_target_i ( pred_target   ),
        .has_room_i    ( has_room      ),
        .mem_req_o     ( mem_req_o     ),
        .mem_addr_o    ( mem_addr_o    ),
        .mem_gnt_i     ( mem_gnt_i     ),
        .mem_rvalid_i  ( mem_rvalid_i  ),
        .mem_rdata_i   ( mem_rdata_i   ),
        .rsp_valid_o   ( rsp_valid     ),
        .rsp_pc_o      ( rsp_pc        ),
        .rsp_instr_o   ( rsp_instr     )
    );

    fe_branch_predict i_branch_predict (
        .rsp_valid_i   ( rsp_valid     ),
        .rsp_pc_i      ( rsp_pc        ),
        .rsp_instr_i   ( rsp_instr     ),
        .pred_taken_o  ( pred_taken    ),
        .pred_target_o ( pred_target   ),
        .push_o        ( push          ),
        .push_pc_o     ( push_pc       ),
        .push_instr_o  ( push_instr    ),
        .push_taken_o  ( push_taken    ),
        .push_npc_o    ( push_npc      )
    );

    // redirect flushes every queued entry
    fe_fetch_queue i_fetch_queue (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_i       ( redirect_i    ),
        .push_i        ( push          ),
        .pc_i          ( push_pc       ),
        .instr_i       ( push_instr    ),
        .taken_i       ( push_taken    ),
        .npc_i         ( push_npc      ),
        .has_room_o    ( has_room      ),
        .valid_o       ( fetch_valid_o ),
        .pc_o          ( fetch_pc_o    ),
        .instr_o       ( fetch_instr_o ),
        .taken_o       ( fetch_taken_o ),
        .npc_o         ( fetch_npc_o   ),
        .ready_i       ( fetch_ready_i )
    );

endmodule

// ==== verif/fe_pipe_props.sv ====
// ----------------------------------------
// handshake assertions of the frontend
// memory request and fetch entry rules
// ----------------------------------------
`timescale 1ns/1ps

module fe_pipe_props (
    input logic               clk_i,
    input logic               rst_ni,
    input logic               mem_req_o,
    input logic               mem_gnt_i,
    input fe_pipe_pkg::addr_t mem_addr_o,
    input logic               redirect_i,
    input logic               fetch_valid_o,
    input logic               fetch_ready_i,
    input fe_pipe_pkg::addr_t fetch_pc_o,
    input fe_isa_pkg::instr_t fetch_instr_o,
    input logic               fetch_taken_o,
    input fe_pipe_pkg::addr_t fetch_npc_o
);
    // stalled request stays up with the same address
    mem_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o))
        else $error("memory request dropped or address moved while stalled");

    // held entry keeps its payload, a redirect may flush it
    fetch_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_valid_o && !fetch_ready_i && !redirect_i |=> fetch_valid_o
        && $stable(fetch_pc_o) && $stable(fetch_instr_o)
        && $stable(fetch_taken_o) && $stable(fetch_npc_o))
        else $error("fetch entry changed while valid and not ready");

    // quiet interfaces in reset
    reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !mem_req_o && !fetch_valid_o)
        else $error("memory request or fetch entry active during reset");

endmodule

// ==== verif/fetch_frontend_tb.sv ====
// ----------------------------------------
// testbench of the fetch frontend
// memory model, walker reference, checks
// ----------------------------------------
`timescale 1ns/1ps
`include "fe_defines.svh"

module fetch_frontend_tb;
    import fe_pipe_pkg::*;
    import fe_isa_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int MEM_WORDS   = 256;
    localparam int RAND_SEED   = 68490;
    localparam int N_STRAIGHT  = 16;
    localparam int N_JAL       = 20;
    localparam int N_BRANCH    = 24;
    localparam int N_RANDOM    = 80;
    localparam int N_REDIRECT  = 30;
    localparam int N_RESET     = 8;
    localparam int TOTAL_ENTRIES = N_STRAIGHT + N_JAL + N_BRANCH + N_RANDOM
                                 + N_REDIRECT + N_RESET;
    localparam int WATCHDOG_NS = TOTAL_ENTRIES * 20 * CLK_PERIOD;
    // word right after the jal at 0x208
    localparam addr_t JAL_SHADOW_PC = 32'h20c;

    logic   clk_i, rst_ni;
    addr_t  boot_addr_i, redirect_pc_i, mem_addr_o;
    logic   redirect_i, mem_req_o, mem_gnt_i, mem_rvalid_i;
    instr_t mem_rdata_i, fetch_instr_o;
    logic   fetch_valid_o, fetch_taken_o, fetch_ready_i;
    addr_t  fetch_pc_o, fetch_npc_o;

    instr_t mem [MEM_WORDS];
    logic   rand_mode;
    addr_t  start_pc, walk_pc;
    string  cur_test;
    int     seen_count, check_count, err_count, errs_at_start;
    int     tests_run, tests_failed;

    fetch_frontend UUT (.*);

    bind fetch_frontend fe_pipe_props u_props (
        .clk_i(clk_i), .rst_ni(rst_ni), .mem_req_o(mem_req_o), .mem_gnt_i(mem_gnt_i),
        .mem_addr_o(mem_addr_o), .redirect_i(redirect_i), .fetch_valid_o(fetch_valid_o),
        .fetch_ready_i(fetch_ready_i), .fetch_pc_o(fetch_pc_o),
        .fetch_instr_o(fetch_instr_o), .fetch_taken_o(fetch_taken_o),
        .fetch_npc_o(fetch_npc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ----------------------------------------
    // program encoding and reference rule
    // ----------------------------------------
    function automatic instr_t enc_jal(input int offset);
        logic [20:0] imm;
        imm = 21'(offset);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `FE_OPC_JAL};
    endfunction

    function automatic instr_t enc_branch(input int offset);
        logic [12:0] imm;
        imm = 13'(offset);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], `FE_OPC_BRANCH};
    endfunction

    function automatic instr_t mem_word(input addr_t a);
        return mem[a[9:2]];
    endfunction

    // jal always, branch only when its offset is negative
    function automatic logic is_taken(input instr_t w);
        return (w[6:0] == `FE_OPC_JAL) || ((w[6:0] == `FE_OPC_BRANCH) && w[31]);
    endfunction

    function automatic addr_t next_pc(input addr_t pc, input instr_t w);
        addr_t imm_b, imm_j;
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        if (w[6:0] == `FE_OPC_JAL) begin
            return pc + imm_j;
        end else if (is_taken(w)) begin
            return pc + imm_b;
        end else begin
            return pc + 32'd4;
        end
    endfunction

    // op-imm filler from the word index, control flow patched in
    task automatic load_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {12'(i) ^ 12'ha5c, 8'(i), 5'd5, 7'b0010011};
        end
        mem[32'h040 >> 2] = enc_branch(8);
        mem[32'h060 >> 2] = enc_jal(32'h300 - 32'h060);
        mem[32'h208 >> 2] = enc_jal(32'h40);
        mem[32'h24c >> 2] = enc_jal(-32'h4c);
        mem[32'h304 >> 2] = enc_branch(32'h10);
        mem[32'h310 >> 2] = enc_branch(-32'h10);
    endtask

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_instr(input string what, input instr_t exp, input instr_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    // ----------------------------------------
    // memory, handshakes, comparator
    // ----------------------------------------
    initial begin : memory_model
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(posedge clk_i);
            if (!rst_ni) begin
                mem_rvalid_i <= 1'b0;
            end else begin
                mem_rvalid_i <= mem_req_o & mem_gnt_i;
                if (mem_req_o && mem_gnt_i) begin
                    mem_rdata_i <= mem_word(mem_addr_o);
                end
            end
        end
    end

    initial begin : drive_handshakes
        mem_gnt_i     = 1'b0;
        fetch_ready_i = 1'b0;
        void'($urandom(RAND_SEED));
        forever begin
            @(posedge clk_i);
            if (rand_mode) begin
                mem_gnt_i     <= ($urandom_range(3) != 0);
                fetch_ready_i <= ($urandom_range(1) != 0);
            end else begin
                mem_gnt_i     <= 1'b1;
                fetch_ready_i <= 1'b1;
            end
        end
    end

    // walker follows the static rule from the boot or redirect pc
    always @(posedge clk_i) begin : compare_entries
        instr_t exp_instr;
        addr_t  exp_npc;
        if (!rst_ni) begin
            walk_pc    = start_pc;
            seen_count = 0;
        end else begin
            if (fetch_valid_o && fetch_ready_i) begin
                exp_instr = mem_word(walk_pc);
                exp_npc   = next_pc(walk_pc, exp_instr);
                check_addr("pc", walk_pc, fetch_pc_o);
                check_instr("instr", exp_instr, fetch_instr_o);
                check_bit("taken", is_taken(exp_instr), fetch_taken_o);
                check_addr("npc", exp_npc, fetch_npc_o);
                if (fetch_pc_o == JAL_SHADOW_PC) begin
                    err_count++;
                    $display("%s: word behind a taken jal was delivered", cur_test);
                end
                walk_pc    = exp_npc;
                seen_count = seen_count + 1;
            end
            if (redirect_i) begin
                walk_pc = redirect_pc_i;
            end
        end
    end

    // ----------------------------------------
    // test sequencing
    // ----------------------------------------
    task automatic begin_test(input string name, input addr_t boot, input logic rnd);
        cur_test      = name;
        errs_at_start = err_count;
        @(posedge clk_i);
        start_pc    = boot;
        rand_mode   <= rnd;
        boot_addr_i <= boot;
        rst_ni      <= 1'b0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
    endtask

    task automatic wait_entries(input int n);
        while (seen_count < n) begin
            @(posedge clk_i);
        end
    endtask

    task automatic end_test(input int n);
        int errs;
        @(posedge clk_i);
        rst_ni <= 1'b0;
        @(posedge clk_i);
        errs = err_count - errs_at_start;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d entries, %0d errors", cur_test, n, errs);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: no completion within %0d ns, entries stopped arriving", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin : run_tests
        logic req_seen, rsp_seen;
        rst_ni        = 1'b1;
        boot_addr_i   = '0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        rand_mode     = 1'b0;
        start_pc      = '0;
        cur_test      = "init";
        check_count   = 0;
        err_count     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        load_memory();

        begin_test("straight_line", 32'h100, 1'b0);
        wait_entries(N_STRAIGHT);
        end_test(N_STRAIGHT);

        begin_test("jal_taken", 32'h200, 1'b0);
        wait_entries(N_JAL);
        end_test(N_JAL);

        begin_test("branch_dir", 32'h300, 1'b0);
        wait_entries(N_BRANCH);
        end_test(N_BRANCH);

        begin_test("random_stall", 32'h000, 1'b1);
        wait_entries(N_RANDOM);
        end_test(N_RANDOM);

        // redirect lands in the jal loop mid-stream
        begin_test("redirect_mid", 32'h100, 1'b1);
        wait_entries(10);
        @(posedge clk_i);
        redirect_i    <= 1'b1;
        redirect_pc_i <= 32'h200;
        @(posedge clk_i);
        redirect_i <= 1'b0;
        wait_entries(N_REDIRECT);
        end_test(N_REDIRECT);

        begin_test("reset_boot", 32'h080, 1'b0);
        req_seen = 1'b0;
        rsp_seen = 1'b0;
        // every cycle from reset release on, until the first entry can be out
        for (int i = 0; i < 6; i++) begin
            @(posedge clk_i);
            if (fetch_valid_o && !rsp_seen) begin
                err_count++;
                $display("reset_boot: fetch entry valid before any memory response");
            end
            if (mem_rvalid_i) begin
                rsp_seen = 1'b1;
            end
            if (mem_req_o && !req_seen) begin
                req_seen = 1'b1;
                check_addr("boot_req", 32'h080, mem_addr_o);
            end
        end
        if (!req_seen) begin
            err_count++;
            $display("reset_boot: no memory request within 6 cycles after reset");
        end
        wait_entries(N_RESET);
        end_test(N_RESET);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== fetch_frontend.f ====
+incdir+design
design/fe_isa_pkg.sv
design/fe_pipe_pkg.sv
design/fe_pc_gen.sv
design/fe_branch_predict.sv
design/fe_fetch_queue.sv
design/fetch_frontend.sv
verif/fe_pipe_props.sv
verif/fetch_frontend_tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch frontend testbench

VERILATOR ?= verilator
TOP       ?= fetch_frontend_tb
FILELIST  ?= fetch_frontend.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard design/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status follows the search for the pass line in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
